/* core_region_mem.f */
+incdir+hdl
hdl/mem_region_pkg.sv
hdl/region_cfg_apb.sv
hdl/lsu_demux.sv
hdl/ram_mux.sv
hdl/sp_ram.sv
hdl/core_region_mem.sv
bench/core_region_mem_properties.sv
bench/core_region_mem_tb.sv

/* Bender.yml */
package:
  name: core_region_mem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_region_pkg.sv
      - hdl/region_cfg_apb.sv
      - hdl/lsu_demux.sv
      - hdl/ram_mux.sv
      - hdl/sp_ram.sv
      - hdl/core_region_mem.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - bench/core_region_mem_properties.sv
      - bench/core_region_mem_tb.sv

/* bench/core_region_mem_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_region_defs.svh"

module core_region_mem_tb import mem_region_pkg::*;
();

  localparam int WAIT_LIMIT = 20;

  logic clk;
  logic rst_n;

  logic psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
  logic [`APB_ADDR_WIDTH-1:0] paddr_i;
  word_t pwdata_i, prdata_o;

  logic lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  be_t lsu_be_i;
  word_t lsu_addr_i, lsu_wdata_i, lsu_rdata_o;

  logic ld_req_i, ld_we_i;
  ram_addr_t ld_addr_i;
  be_t ld_be_i;
  word_t ld_wdata_i, ld_rdata_o;

  logic ext_req_o, ext_we_o, ext_gnt_i, ext_rvalid_i;
  be_t ext_be_o;
  word_t ext_addr_o, ext_wdata_o, ext_rdata_i;

  // Reference state
  word_t ref_mem [0:(1 << `RAM_ADDR_WIDTH)-1];
  region_t exp_region;
  logic [31:0] lfsr_q = 32'h28ac9f92;
  int mismatches = 0;
  int failures = 0;

  // Transfer currently driven on the load/store port
  word_t cur_addr, cur_wdata;
  logic cur_we, cur_local;
  be_t cur_be;

  core_region_mem i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic word_t byte_merge(input word_t old, input word_t wdata, input be_t be);
    word_t res;
    res = old;
    for (int i = 0; i < `BE_WIDTH; i++)
    begin
      if (be[i])
        res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  function automatic word_t local_addr(input region_t tag, input ram_addr_t idx);
    word_t r;
    r = rand_bits(8);
    return {tag, r[7:0], idx, 2'b00};
  endfunction

  function automatic word_t outside_addr(input region_t tag);
    word_t a;
    a = rand_bits(32);
    if (a[`REGION_MSB:`REGION_LSB] == tag)
      a[31] = ~a[31];
    return a;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp)
    else
    begin
      mismatches++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic apb_xfer(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                          input word_t wdata, output word_t rdata, output logic err);
    logic done;
    @(negedge clk);
    psel_i = 1'b1;
    pwrite_i = write;
    paddr_i = addr;
    pwdata_i = wdata;
    @(negedge clk);
    penable_i = 1'b1;
    done = 1'b0;
    for (int cnt = 0; cnt < WAIT_LIMIT && !done; cnt++)
    begin
      @(posedge clk);
      done = pready_o;
    end
    rdata = prdata_o;
    err = pslverr_o;
    if (!done)
    begin
      failures++;
      $display("Timeout waiting for pready_o");
    end
    @(negedge clk);
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
  endtask

  task automatic set_region(input region_t tag);
    word_t rd;
    logic err;
    apb_xfer(1'b1, `CFG_REGION_OFFSET, word_t'(tag), rd, err);
    check_word("pslverr_o", 0, err);
    exp_region = tag;
  endtask

  task automatic lsu_access(input word_t addr, input logic we, input be_t be,
                            input word_t wdata, output word_t rdata);
    logic seen;
    int lat;
    cur_addr = addr;
    cur_we = we;
    cur_be = be;
    cur_wdata = wdata;
    cur_local = (addr[`REGION_MSB:`REGION_LSB] == exp_region);
    @(negedge clk);
    lsu_req_i = 1'b1;
    lsu_addr_i = addr;
    lsu_we_i = we;
    lsu_be_i = be;
    lsu_wdata_i = wdata;
    seen = 1'b0;
    for (int cnt = 0; cnt < WAIT_LIMIT && !seen; cnt++)
    begin
      @(posedge clk);
      seen = lsu_gnt_o;
      assert (!(seen && ld_req_i && cur_local))
      else
      begin
        failures++;
        $display("lsu_gnt_o went high while the loader held the RAM");
      end
    end
    if (!seen)
    begin
      failures++;
      $display("Timeout waiting for lsu_gnt_o at address %h", addr);
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
    seen = 1'b0;
    lat = 0;
    while (!seen && lat < WAIT_LIMIT)
    begin
      @(posedge clk);
      lat++;
      seen = lsu_rvalid_o;
    end
    rdata = lsu_rdata_o;
    if (!seen)
    begin
      failures++;
      $display("Timeout waiting for lsu_rvalid_o at address %h", addr);
    end
    else if (cur_local && lat != 1)
    begin
      failures++;
      $display("Local response came %0d cycles after the grant", lat);
    end
  endtask

  task automatic ld_access(input ram_addr_t idx, input logic we, input be_t be,
                           input word_t wdata, input int hold, output word_t rdata);
    @(negedge clk);
    ld_req_i = 1'b1;
    ld_addr_i = idx;
    ld_we_i = we;
    ld_be_i = be;
    ld_wdata_i = wdata;
    repeat (hold) @(negedge clk);
    ld_req_i = 1'b0;
    ld_we_i = 1'b0;
    @(posedge clk);
    rdata = ld_rdata_o;
  endtask

  // External slave with random grant and response delays
  initial
  begin : ext_bus_model
    int dly;
    word_t seen_addr;
    ext_gnt_i = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i = '0;
    forever
    begin
      @(posedge clk);
      if (rst_n && ext_req_o)
      begin
        assert (!cur_local)
        else
        begin
          failures++;
          $display("External request raised for local address %h", ext_addr_o);
        end
        dly = rand_bits(2);
        repeat (dly) @(negedge clk);
        @(negedge clk);
        ext_gnt_i = 1'b1;
        @(posedge clk);
        check_word("ext_req_o", 1, ext_req_o);
        check_word("ext_addr_o", cur_addr, ext_addr_o);
        check_word("ext_we_o", cur_we, ext_we_o);
        check_word("ext_be_o", cur_be, ext_be_o);
        check_word("ext_wdata_o", cur_wdata, ext_wdata_o);
        seen_addr = ext_addr_o;
        @(negedge clk);
        ext_gnt_i = 1'b0;
        dly = rand_bits(2);
        repeat (dly) @(negedge clk);
        ext_rvalid_i = 1'b1;
        ext_rdata_i = ~seen_addr;
        @(negedge clk);
        ext_rvalid_i = 1'b0;
        ext_rdata_i = '0;
      end
    end
  end

  initial
  begin : stimulus
    word_t addrs [8];
    word_t addr;
    word_t data;
    word_t rd;
    word_t ld_rd;
    logic err;
    logic we;
    ram_addr_t idx;
    be_t be;
    int prop_fails;

    rst_n = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    lsu_req_i = 1'b0;
    lsu_addr_i = '0;
    lsu_we_i = 1'b0;
    lsu_be_i = '0;
    lsu_wdata_i = '0;
    ld_req_i = 1'b0;
    ld_addr_i = '0;
    ld_we_i = 1'b0;
    ld_be_i = '0;
    ld_wdata_i = '0;
    cur_local = 1'b0;
    exp_region = `REGION_RESET;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle outputs after reset
    check_word("lsu_gnt_o", 0, lsu_gnt_o);
    check_word("lsu_rvalid_o", 0, lsu_rvalid_o);
    check_word("ext_req_o", 0, ext_req_o);
    check_word("pslverr_o", 0, pslverr_o);
    check_word("ram_en", 0, i_dut.ram_en);

    // Region register
    apb_xfer(1'b0, `CFG_REGION_OFFSET, '0, rd, err);
    check_word("prdata_o", `REGION_RESET, rd);
    set_region(12'h3c7);
    apb_xfer(1'b0, `CFG_REGION_OFFSET, '0, rd, err);
    check_word("prdata_o", 32'h3c7, rd);
    apb_xfer(1'b1, 4'h4, 32'h5a5, rd, err);
    check_word("pslverr_o", 1, err);
    apb_xfer(1'b0, 4'h8, '0, rd, err);
    check_word("pslverr_o", 1, err);
    apb_xfer(1'b0, `CFG_REGION_OFFSET, '0, rd, err);
    check_word("prdata_o", 32'h3c7, rd);
    set_region(`REGION_RESET);

    // Full writes first so no byte stays unknown
    for (int i = 0; i < 8; i++)
    begin
      idx = rand_bits(`RAM_ADDR_WIDTH);
      addrs[i] = local_addr(exp_region, idx);
      data = rand_bits(32);
      lsu_access(addrs[i], 1'b1, 4'hf, data, rd);
      ref_mem[idx] = data;
    end
    for (int i = 0; i < 8; i++)
    begin
      be = rand_bits(`BE_WIDTH);
      data = rand_bits(32);
      idx = addrs[i][`RAM_ADDR_WIDTH+1:2];
      lsu_access(addrs[i], 1'b1, be, data, rd);
      ref_mem[idx] = byte_merge(ref_mem[idx], data, be);
    end
    for (int i = 0; i < 8; i++)
    begin
      lsu_access(addrs[i], 1'b0, 4'hf, '0, rd);
      check_word("lsu_rdata_o", ref_mem[addrs[i][`RAM_ADDR_WIDTH+1:2]], rd);
    end

    // Outside the region, reads and writes in turn
    for (int i = 0; i < 6; i++)
    begin
      addr = outside_addr(exp_region);
      we = i[0];
      be = rand_bits(`BE_WIDTH);
      data = rand_bits(32);
      lsu_access(addr, we, be, data, rd);
      if (!we)
        check_word("lsu_rdata_o", ~addr, rd);
    end

    // Loader and core sharing the RAM
    idx = rand_bits(`RAM_ADDR_WIDTH);
    data = rand_bits(32);
    ld_access(idx, 1'b1, 4'hf, data, 1, ld_rd);
    ref_mem[idx] = data;
    lsu_access(local_addr(exp_region, idx), 1'b0, 4'hf, '0, rd);
    check_word("lsu_rdata_o", ref_mem[idx], rd);
    idx = rand_bits(`RAM_ADDR_WIDTH);
    data = rand_bits(32);
    lsu_access(local_addr(exp_region, idx), 1'b1, 4'hf, data, rd);
    ref_mem[idx] = data;
    ld_access(idx, 1'b0, 4'h0, '0, 1, ld_rd);
    check_word("ld_rdata_o", ref_mem[idx], ld_rd);

    // Loader held over a pending core read
    idx = addrs[0][`RAM_ADDR_WIDTH+1:2];
    data = rand_bits(32);
    fork
      ld_access(idx, 1'b1, 4'hf, data, 5, ld_rd);
      lsu_access(addrs[1], 1'b0, 4'hf, '0, rd);
    join
    ref_mem[idx] = data;
    check_word("lsu_rdata_o", ref_mem[addrs[1][`RAM_ADDR_WIDTH+1:2]], rd);

    // New tag moves the local window
    set_region(12'h155);
    idx = rand_bits(`RAM_ADDR_WIDTH);
    data = rand_bits(32);
    lsu_access(local_addr(12'h155, idx), 1'b1, 4'hf, data, rd);
    ref_mem[idx] = data;
    lsu_access(local_addr(12'h155, idx), 1'b0, 4'hf, '0, rd);
    check_word("lsu_rdata_o", ref_mem[idx], rd);
    addr = local_addr(`REGION_RESET, idx);
    lsu_access(addr, 1'b0, 4'hf, '0, rd);
    check_word("lsu_rdata_o", ~addr, rd);

    repeat (4) @(posedge clk);
    prop_fails = i_dut.i_lsu_demux.i_demux_props.fail_count
               + i_dut.i_ram_mux.i_mux_props.fail_count;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, prop_fails);
    if (mismatches == 0 && failures == 0 && prop_fails == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/core_region_mem_properties.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_region_defs.svh"

module core_region_mem_properties import mem_region_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    gnt_i,
  input  logic    rvalid_i,
  input  logic    ld_req_i,
  input  logic    ext_req_i,
  input  word_t   ext_addr_i,
  input  region_t region_i
);

  int unsigned fail_count = 0;

  // Local response exactly one cycle after a local grant
  a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    gnt_i |=> rvalid_i)
  else
  begin
    fail_count++;
    $error("local response missing one cycle after the grant");
  end

  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    !gnt_i |=> !rvalid_i)
  else
  begin
    fail_count++;
    $error("local response without a grant in the cycle before");
  end

  // Loader owns the RAM while it requests
  a_loader_priority: assert property (@(posedge clk) disable iff (!rst_n)
    ld_req_i |-> !gnt_i)
  else
  begin
    fail_count++;
    $error("local grant while the loader requests");
  end

  a_ext_outside_region: assert property (@(posedge clk) disable iff (!rst_n)
    ext_req_i |-> (ext_addr_i[`REGION_MSB:`REGION_LSB] != region_i))
  else
  begin
    fail_count++;
    $error("external request with an address inside the local region");
  end

endmodule

bind lsu_demux core_region_mem_properties i_demux_props (
  .clk        ( clk                   ),
  .rst_n      ( rst_n                 ),
  .gnt_i      ( loc_req_o & loc_gnt_i ),
  .rvalid_i   ( loc_rvalid_i          ),
  .ld_req_i   ( 1'b0                  ),
  .ext_req_i  ( ext_req_o             ),
  .ext_addr_i ( ext_addr_o            ),
  .region_i   ( region_i              )
);

bind ram_mux core_region_mem_properties i_mux_props (
  .clk        ( clk           ),
  .rst_n      ( rst_n         ),
  .gnt_i      ( core_gnt_o    ),
  .rvalid_i   ( core_rvalid_o ),
  .ld_req_i   ( ld_req_i      ),
  .ext_req_i  ( 1'b0          ),
  .ext_addr_i ( '0            ),
  .region_i   ( '0            )
);

`default_nettype wire

/* hdl/core_region_mem.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_region_defs.svh"

module core_region_mem import mem_region_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,

  // APB configuration
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`APB_ADDR_WIDTH-1:0] paddr_i,
  input  word_t                      pwdata_i,
  output word_t                      prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,

  // Core load/store
  input  logic                       lsu_req_i,
  input  word_t                      lsu_addr_i,
  input  logic                       lsu_we_i,
  input  be_t                        lsu_be_i,
  input  word_t                      lsu_wdata_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output word_t                      lsu_rdata_o,

  // Loader
  input  logic                       ld_req_i,
  input  ram_addr_t                  ld_addr_i,
  input  logic                       ld_we_i,
  input  be_t                        ld_be_i,
  input  word_t                      ld_wdata_i,
  output word_t                      ld_rdata_o,

  // External bus
  output logic                       ext_req_o,
  output word_t                      ext_addr_o,
  output logic                       ext_we_o,
  output be_t                        ext_be_o,
  output word_t                      ext_wdata_o,
  input  logic                       ext_gnt_i,
  input  logic                       ext_rvalid_i,
  input  word_t                      ext_rdata_i
);

  region_t   region;

  logic      loc_req;
  ram_addr_t loc_addr;
  logic      loc_we;
  be_t       loc_be;
  word_t     loc_wdata;
  logic      loc_gnt;
  logic      loc_rvalid;
  word_t     loc_rdata;

  logic      ram_en;
  ram_addr_t ram_addr;
  logic      ram_we;
  be_t       ram_be;
  word_t     ram_wdata;
  word_t     ram_rdata;

  region_cfg_apb i_region_cfg_apb (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .prdata_o  ( prdata_o  ),
    .pready_o  ( pready_o  ),
    .pslverr_o ( pslverr_o ),
    .region_o  ( region    )
  );

  lsu_demux i_lsu_demux (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .region_i     ( region       ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .loc_req_o    ( loc_req      ),
    .loc_addr_o   ( loc_addr     ),
    .loc_we_o     ( loc_we       ),
    .loc_be_o     ( loc_be       ),
    .loc_wdata_o  ( loc_wdata    ),
    .loc_gnt_i    ( loc_gnt      ),
    .loc_rvalid_i ( loc_rvalid   ),
    .loc_rdata_i  ( loc_rdata    ),
    .ext_req_o    ( ext_req_o    ),
    .ext_addr_o   ( ext_addr_o   ),
    .ext_we_o     ( ext_we_o     ),
    .ext_be_o     ( ext_be_o     ),
    .ext_wdata_o  ( ext_wdata_o  ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  )
  );

  ram_mux i_ram_mux (
    .clk           ( clk        ),
    .rst_n         ( rst_n      ),
    .ld_req_i      ( ld_req_i   ),
    .ld_addr_i     ( ld_addr_i  ),
    .ld_we_i       ( ld_we_i    ),
    .ld_be_i       ( ld_be_i    ),
    .ld_wdata_i    ( ld_wdata_i ),
    .ld_rdata_o    ( ld_rdata_o ),
    .core_req_i    ( loc_req    ),
    .core_addr_i   ( loc_addr   ),
    .core_we_i     ( loc_we     ),
    .core_be_i     ( loc_be     ),
    .core_wdata_i  ( loc_wdata  ),
    .core_gnt_o    ( loc_gnt    ),
    .core_rvalid_o ( loc_rvalid ),
    .core_rdata_o  ( loc_rdata  ),
    .ram_en_o      ( ram_en     ),
    .ram_addr_o    ( ram_addr   ),
    .ram_we_o      ( ram_we     ),
    .ram_be_o      ( ram_be     ),
    .ram_wdata_o   ( ram_wdata  ),
    .ram_rdata_i   ( ram_rdata  )
  );

  sp_ram i_sp_ram (
    .clk     ( clk       ),
    .en_i    ( ram_en    ),
    .we_i    ( ram_we    ),
    .addr_i  ( ram_addr  ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

`default_nettype wire

/* hdl/sp_ram.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_region_defs.svh"

module sp_ram import mem_region_pkg::*;
(
  input  logic      clk,

  input  logic      en_i,
  input  logic      we_i,
  input  ram_addr_t addr_i,
  input  be_t       be_i,
  input  word_t     wdata_i,
  output word_t     rdata_o
);

  word_t mem [0:(1 << `RAM_ADDR_WIDTH)-1];

  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        // Only the enabled bytes change
        for (int i = 0; i < `BE_WIDTH; i++)
        begin
          if (be_i[i])
          begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      else
      begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ram_mux.sv */
`default_nettype none
`timescale 1ns/1ns

module ram_mux import mem_region_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Loader port, always wins
  input  logic      ld_req_i,
  input  ram_addr_t ld_addr_i,
  input  logic      ld_we_i,
  input  be_t       ld_be_i,
  input  word_t     ld_wdata_i,
  output word_t     ld_rdata_o,

  // Core port
  input  logic      core_req_i,
  input  ram_addr_t core_addr_i,
  input  logic      core_we_i,
  input  be_t       core_be_i,
  input  word_t     core_wdata_i,
  output logic      core_gnt_o,
  output logic      core_rvalid_o,
  output word_t     core_rdata_o,

  // Single-port RAM
  output logic      ram_en_o,
  output ram_addr_t ram_addr_o,
  output logic      ram_we_o,
  output be_t       ram_be_o,
  output word_t     ram_wdata_o,
  input  word_t     ram_rdata_i
);

  logic rvalid_q;

  // Loader back-pressure stalls the core
  assign core_gnt_o = core_req_i & ~ld_req_i;

  assign ram_en_o    = ld_req_i | core_req_i;
  assign ram_addr_o  = ld_req_i ? ld_addr_i  : core_addr_i;
  assign ram_we_o    = ld_req_i ? ld_we_i    : core_we_i;
  assign ram_be_o    = ld_req_i ? ld_be_i    : core_be_i;
  assign ram_wdata_o = ld_req_i ? ld_wdata_i : core_wdata_i;

  // RAM answers one cycle after the grant
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid_q <= 1'b0;
    end
    else
    begin
      rvalid_q <= core_gnt_o;
    end
  end

  assign core_rvalid_o = rvalid_q;

  assign ld_rdata_o   = ram_rdata_i;
  assign core_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

/* hdl/lsu_demux.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_region_defs.svh"

module lsu_demux import mem_region_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  region_t   region_i,

  // Load/store port
  input  logic      lsu_req_i,
  input  word_t     lsu_addr_i,
  input  logic      lsu_we_i,
  input  be_t       lsu_be_i,
  input  word_t     lsu_wdata_i,
  output logic      lsu_gnt_o,
  output logic      lsu_rvalid_o,
  output word_t     lsu_rdata_o,

  // Local RAM side
  output logic      loc_req_o,
  output ram_addr_t loc_addr_o,
  output logic      loc_we_o,
  output be_t       loc_be_o,
  output word_t     loc_wdata_o,
  input  logic      loc_gnt_i,
  input  logic      loc_rvalid_i,
  input  word_t     loc_rdata_i,

  // External bus side
  output logic      ext_req_o,
  output word_t     ext_addr_o,
  output logic      ext_we_o,
  output be_t       ext_be_o,
  output word_t     ext_wdata_o,
  input  logic      ext_gnt_i,
  input  logic      ext_rvalid_i,
  input  word_t     ext_rdata_i
);

  target_e tgt_q;
  logic    is_local;

  assign is_local = (lsu_addr_i[`REGION_MSB:`REGION_LSB] == region_i);

  assign loc_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // Byte address down to RAM word index
  assign loc_addr_o  = lsu_addr_i[`RAM_ADDR_WIDTH+1:2];
  assign loc_we_o    = lsu_we_i;
  assign loc_be_o    = lsu_be_i;
  assign loc_wdata_o = lsu_wdata_i;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = (loc_req_o & loc_gnt_i) | (ext_req_o & ext_gnt_i);

  // Remember where the accepted transfer went
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      tgt_q <= TGT_RAM;
    end
    else if (lsu_gnt_o)
    begin
      tgt_q <= is_local ? TGT_RAM : TGT_EXT;
    end
  end

  // Response comes from the recorded target
  always_comb
  begin
    if (tgt_q == TGT_EXT)
    begin
      lsu_rvalid_o = ext_rvalid_i;
      lsu_rdata_o  = ext_rdata_i;
    end
    else
    begin
      lsu_rvalid_o = loc_rvalid_i;
      lsu_rdata_o  = loc_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/region_cfg_apb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_region_defs.svh"

module region_cfg_apb import mem_region_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`APB_ADDR_WIDTH-1:0] paddr_i,
  input  word_t                      pwdata_i,
  output word_t                      prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,

  output region_t                    region_o
);

  region_t region_q;
  logic    reg_hit;
  logic    access;

  assign reg_hit = (paddr_i == `CFG_REGION_OFFSET);

  // Access phase of an APB transfer
  assign access = psel_i & penable_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      region_q <= `REGION_RESET;
    end
    else if (access && pwrite_i && reg_hit)
    begin
      region_q <= pwdata_i[`REGION_MSB-`REGION_LSB:0];
    end
  end

  // Tag read back zero-extended
  always_comb
  begin
    prdata_o = '0;
    if (psel_i && !pwrite_i && reg_hit)
    begin
      prdata_o = word_t'(region_q);
    end
  end

  // No wait states
  assign pready_o = 1'b1;

  // Unmapped offsets flag an error and leave the tag alone
  assign pslverr_o = access & ~reg_hit;

  assign region_o = region_q;

endmodule

`default_nettype wire

/* hdl/mem_region_pkg.sv */
`default_nettype none

`include "mem_region_defs.svh"

package mem_region_pkg;

  // One data or address word
  typedef logic [`DATA_WIDTH-1:0] word_t;

  typedef logic [`BE_WIDTH-1:0] be_t;

  // Word index into the data RAM
  typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

  typedef logic [`REGION_MSB-`REGION_LSB:0] region_t;

  // Where the response of the last granted request comes from
  typedef enum logic {
    TGT_RAM = 1'b0,
    TGT_EXT = 1'b1
  } target_e;

endpackage

`default_nettype wire

/* hdl/mem_region_defs.svh */
`ifndef MEM_REGION_DEFS_SVH
`define MEM_REGION_DEFS_SVH

// Data RAM depth as word-index bits (1024 words)
`define RAM_ADDR_WIDTH 10

// Bus word and byte enables
`define DATA_WIDTH 32
`define BE_WIDTH 4

// Address field compared against the region tag
`define REGION_MSB 31
`define REGION_LSB 20
`define REGION_RESET 12'h001

// Configuration register map
`define APB_ADDR_WIDTH 4
`define CFG_REGION_OFFSET 4'h0

`endif
